// ==== div_unit_settings.svh ====
`ifndef DIV_UNIT_SETTINGS_SVH
`define DIV_UNIT_SETTINGS_SVH

// operand and result width.
`define DIV_WIDTH 32

// physical destination register tag.
`define DIV_TAG_W 7

// instruction address width.
`define DIV_PC_W 32

// one quotient bit per stage.
`define DIV_STAGES `DIV_WIDTH

`endif

// ==== div_unit_pkg.sv ====
`include "div_unit_settings.svh"

package div_unit_pkg;

    typedef logic [`DIV_WIDTH-1:0] word_t;
    typedef logic [`DIV_TAG_W-1:0] tag_t;
    typedef logic [`DIV_PC_W-1:0]  pc_t;
    typedef logic [1:0]            div_op_t;

    // opcodes.
    localparam div_op_t OP_DIV  = 2'b00;
    localparam div_op_t OP_DIVU = 2'b01;
    localparam div_op_t OP_REM  = 2'b10;
    localparam div_op_t OP_REMU = 2'b11;

    localparam int SIDE_W = 4;

    typedef logic [SIDE_W-1:0] side_t;

    // side-band bit positions.
    localparam int SIDE_WANT_REM = 0;
    localparam int SIDE_NEG_Q    = 1;
    localparam int SIDE_NEG_R    = 2;
    localparam int SIDE_ZERO_DIV = 3;

endpackage

// ==== div_issue.sv ====
`timescale 1ns/1ps
`include "div_unit_settings.svh"

module div_issue import div_unit_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    issue_valid,
    input  div_op_t issue_op,
    input  word_t   issue_a,
    input  word_t   issue_b,
    input  tag_t    issue_tag,
    input  pc_t     issue_pc,
    output logic    div_valid,
    output word_t   div_dividend,
    output word_t   div_divisor,
    output tag_t    div_tag,
    output pc_t     div_pc,
    output side_t   div_side
);

    logic  is_signed;
    logic  a_neg;
    logic  b_neg;
    word_t a_mag;
    word_t b_mag;
    side_t side_nxt;

    assign is_signed = (issue_op == OP_DIV) || (issue_op == OP_REM);

    // sign bits only count for DIV and REM.
    assign a_neg = is_signed && issue_a[`DIV_WIDTH-1];
    assign b_neg = is_signed && issue_b[`DIV_WIDTH-1];

    // the most negative value maps onto itself, which is still the right magnitude.
    assign a_mag = a_neg ? -issue_a : issue_a;
    assign b_mag = b_neg ? -issue_b : issue_b;

    always_comb begin
        side_nxt = '0;
        side_nxt[SIDE_WANT_REM] = (issue_op == OP_REM) || (issue_op == OP_REMU);
        side_nxt[SIDE_NEG_Q]    = a_neg ^ b_neg;
        side_nxt[SIDE_NEG_R]    = a_neg;
        side_nxt[SIDE_ZERO_DIV] = (issue_b == '0);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_valid    <= 1'b0;
            div_dividend <= '0;
            div_divisor  <= '0;
            div_tag      <= '0;
            div_pc       <= '0;
            div_side     <= '0;
        end else begin
            div_valid    <= issue_valid;
            div_dividend <= a_mag;
            div_divisor  <= b_mag;
            div_tag      <= issue_tag;
            div_pc       <= issue_pc;
            div_side     <= side_nxt;
        end
    end

    // opcode must be clean when an operation is issued.
    assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> !$isunknown(issue_op))
        else $error("div_issue: unknown opcode on issue");

endmodule

// ==== div_pipe.sv ====
`timescale 1ns/1ps
`include "div_unit_settings.svh"

module div_pipe import div_unit_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  div_valid,
    input  word_t div_dividend,
    input  word_t div_divisor,
    input  tag_t  div_tag,
    input  pc_t   div_pc,
    input  side_t div_side,
    output logic  q_valid,
    output word_t q_quot,
    output word_t q_rem,
    output tag_t  q_tag,
    output pc_t   q_pc,
    output side_t q_side
);

    localparam int W     = `DIV_WIDTH;
    localparam int ACC_W = 2 * W;
    localparam int LAST  = `DIV_STAGES - 1;
    localparam int LAT   = `DIV_STAGES + 1;

    // upper half is the partial remainder, lower half shifts dividend out and quotient in.
    logic [ACC_W-1:0] acc_r   [0:LAST];
    logic [ACC_W-1:0] acc_nxt [0:LAST];
    word_t            dvsr_r  [0:LAST];
    tag_t             tag_r   [0:LAST];
    pc_t              pc_r    [0:LAST];
    side_t            side_r  [0:LAST];
    logic [LAST:0]    vld_r;
    logic [6:0]       hist_cnt;

    genvar i;
    generate
        for (i = 0; i <= LAST; i++) begin : g_step
            logic [W:0] trial;
            logic [W:0] diff;

            // shifted remainder with the next dividend bit appended.
            assign trial = acc_r[i][ACC_W-1:W-1];
            assign diff  = trial - {1'b0, dvsr_r[i]};

            // no borrow means the divisor fits.
            assign acc_nxt[i] = diff[W] ? {trial[W-1:0], acc_r[i][W-2:0], 1'b0}
                                        : {diff[W-1:0], acc_r[i][W-2:0], 1'b1};
        end
    endgenerate

    always_ff @(posedge clk) begin
        acc_r[0]  <= {{W{1'b0}}, div_dividend};
        dvsr_r[0] <= div_divisor;
        tag_r[0]  <= div_tag;
        pc_r[0]   <= div_pc;
        side_r[0] <= div_side;
        for (int s = 1; s <= LAST; s++) begin
            acc_r[s]  <= acc_nxt[s-1];
            dvsr_r[s] <= dvsr_r[s-1];
            tag_r[s]  <= tag_r[s-1];
            pc_r[s]   <= pc_r[s-1];
            side_r[s] <= side_r[s-1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_r <= '0;
        end else begin
            vld_r <= {vld_r[LAST-1:0], div_valid};
        end
    end

    // last step folds into the output register.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q_valid <= 1'b0;
            q_quot  <= '0;
            q_rem   <= '0;
            q_tag   <= '0;
            q_pc    <= '0;
            q_side  <= '0;
        end else begin
            q_valid <= vld_r[LAST];
            q_quot  <= acc_nxt[LAST][W-1:0];
            q_rem   <= acc_nxt[LAST][ACC_W-1:W];
            q_tag   <= tag_r[LAST];
            q_pc    <= pc_r[LAST];
            q_side  <= side_r[LAST];
        end
    end

    // cycles since reset, saturating once the latency window is covered.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_cnt <= '0;
        end else if (hist_cnt != 7'(LAT)) begin
            hist_cnt <= hist_cnt + 7'd1;
        end
    end

    // each operation leaves exactly LAT cycles after it entered.
    assert property (@(posedge clk) disable iff (rst || hist_cnt != 7'(LAT))
        q_valid == $past(div_valid, LAT))
        else $error("div_pipe: q_valid does not match div_valid %0d cycles earlier", LAT);

endmodule

// ==== div_result.sv ====
`timescale 1ns/1ps

module div_result import div_unit_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  q_valid,
    input  word_t q_quot,
    input  word_t q_rem,
    input  tag_t  q_tag,
    input  pc_t   q_pc,
    input  side_t q_side,
    output logic  wb_valid,
    output word_t wb_data,
    output tag_t  wb_tag,
    output pc_t   wb_pc
);

    word_t quot_fix;
    word_t rem_fix;
    word_t data_nxt;

    // divide by zero returns all ones whatever the signs.
    always_comb begin
        if (q_side[SIDE_ZERO_DIV]) begin
            quot_fix = '1;
        end else if (q_side[SIDE_NEG_Q]) begin
            quot_fix = -q_quot;
        end else begin
            quot_fix = q_quot;
        end
    end

    // remainder follows the dividend sign.
    assign rem_fix = q_side[SIDE_NEG_R] ? -q_rem : q_rem;

    assign data_nxt = q_side[SIDE_WANT_REM] ? rem_fix : quot_fix;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_data  <= '0;
            wb_tag   <= '0;
            wb_pc    <= '0;
        end else begin
            wb_valid <= q_valid;
            wb_data  <= data_nxt;
            wb_tag   <= q_tag;
            wb_pc    <= q_pc;
        end
    end

    // side-band bits steer the result, so they must be known.
    assert property (@(posedge clk) disable iff (rst)
        q_valid |-> !$isunknown(q_side))
        else $error("div_result: unknown side-band bits with q_valid");

endmodule

// ==== div_unit.sv ====
`timescale 1ns/1ps

module div_unit import div_unit_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    issue_valid,
    input  div_op_t issue_op,
    input  word_t   issue_a,
    input  word_t   issue_b,
    input  tag_t    issue_tag,
    input  pc_t     issue_pc,
    output logic    wb_valid,
    output word_t   wb_data,
    output tag_t    wb_tag,
    output pc_t     wb_pc
);

    logic  div_valid;
    word_t div_dividend;
    word_t div_divisor;
    tag_t  div_tag;
    pc_t   div_pc;
    side_t div_side;

    logic  q_valid;
    word_t q_quot;
    word_t q_rem;
    tag_t  q_tag;
    pc_t   q_pc;
    side_t q_side;

    div_issue u_issue (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_tag    (issue_tag),
        .issue_pc     (issue_pc),
        .div_valid    (div_valid),
        .div_dividend (div_dividend),
        .div_divisor  (div_divisor),
        .div_tag      (div_tag),
        .div_pc       (div_pc),
        .div_side     (div_side)
    );

    // unsigned magnitudes only from here to the result stage.
    div_pipe u_pipe (
        .clk          (clk),
        .rst          (rst),
        .div_valid    (div_valid),
        .div_dividend (div_dividend),
        .div_divisor  (div_divisor),
        .div_tag      (div_tag),
        .div_pc       (div_pc),
        .div_side     (div_side),
        .q_valid      (q_valid),
        .q_quot       (q_quot),
        .q_rem        (q_rem),
        .q_tag        (q_tag),
        .q_pc         (q_pc),
        .q_side       (q_side)
    );

    div_result u_result (
        .clk      (clk),
        .rst      (rst),
        .q_valid  (q_valid),
        .q_quot   (q_quot),
        .q_rem    (q_rem),
        .q_tag    (q_tag),
        .q_pc     (q_pc),
        .q_side   (q_side),
        .wb_valid (wb_valid),
        .wb_data  (wb_data),
        .wb_tag   (wb_tag),
        .wb_pc    (wb_pc)
    );

endmodule

// ==== tb_div_unit.sv ====
`timescale 1ns/1ps
`include "div_unit_settings.svh"

module tb_div_unit import div_unit_pkg::*; ();

    // issue edge to wb_valid edge: issue, 33 pipe cycles, result.
    localparam int LATENCY        = `DIV_STAGES + 3;
    // about 750 cycles of stimulus and drain, doubled.
    localparam int TIMEOUT_CYCLES = 1500;
    localparam int RESET_CYCLES   = 8;
    localparam int B2B_OPS        = 200;
    localparam int GAP_OPS        = 120;

    typedef struct packed {
        word_t data;
        tag_t  tag;
        pc_t   pc;
        int    due;
    } exp_t;

    logic    clk;
    logic    rst;
    logic    issue_valid;
    div_op_t issue_op;
    word_t   issue_a;
    word_t   issue_b;
    tag_t    issue_tag;
    pc_t     issue_pc;
    logic    wb_valid;
    word_t   wb_data;
    tag_t    wb_tag;
    pc_t     wb_pc;

    exp_t exp_q[$];
    int   cycle;
    int   data_errs;
    int   tag_errs;
    int   pc_errs;
    int   flow_errs;
    int   issued;
    tag_t next_tag;
    pc_t  next_pc;

    div_unit DUT (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_tag   (issue_tag),
        .issue_pc    (issue_pc),
        .wb_valid    (wb_valid),
        .wb_data     (wb_data),
        .wb_tag      (wb_tag),
        .wb_pc       (wb_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // RISC-V divide rules.
    function automatic word_t ref_div(input div_op_t op, input word_t a, input word_t b);
        int    sa;
        int    sb;
        word_t quot;
        word_t rem;
        sa = a;
        sb = b;
        if (b == '0) begin
            quot = '1;
            rem  = a;
        end else if (op == OP_DIVU || op == OP_REMU) begin
            quot = a / b;
            rem  = a % b;
        end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            quot = a;
            rem  = '0;
        end else begin
            // signed divide truncates toward zero.
            quot = sa / sb;
            rem  = sa % sb;
        end
        return (op == OP_REM || op == OP_REMU) ? rem : quot;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            data_errs++;
        end
    endtask

    task automatic check_tag(input string name, input tag_t exp, input tag_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            tag_errs++;
        end
    endtask

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            pc_errs++;
        end
    endtask

    task automatic send_op(input div_op_t op, input word_t a, input word_t b,
                           input tag_t tag, input pc_t pc);
        exp_t e;
        @(posedge clk);
        issue_valid <= 1'b1;
        issue_op    <= op;
        issue_a     <= a;
        issue_b     <= b;
        issue_tag   <= tag;
        issue_pc    <= pc;
        e.data = ref_div(op, a, b);
        e.tag  = tag;
        e.pc   = pc;
        // cycle still holds the count before this edge, so one more gives the issue edge.
        e.due  = cycle + 1 + LATENCY;
        exp_q.push_back(e);
        issued++;
    endtask

    task automatic send_seq(input div_op_t op, input word_t a, input word_t b);
        send_op(op, a, b, next_tag, next_pc);
        next_tag = next_tag + 1'b1;
        next_pc  = next_pc + 32'd4;
    endtask

    task automatic send_random();
        div_op_t op;
        word_t   a;
        word_t   b;
        op = div_op_t'($urandom_range(3));
        a  = $urandom;
        // spread divisor sizes so quotients are not mostly zero.
        b  = $urandom >> $urandom_range(31);
        if ($urandom_range(1) == 1) begin
            b = -b;
        end
        if ($urandom_range(15) == 0) begin
            b = '0;
        end
        send_op(op, a, b, tag_t'($urandom), $urandom);
    endtask

    // idle slots carry junk data that must be ignored.
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            issue_valid <= 1'b0;
            issue_a     <= $urandom;
            issue_b     <= $urandom;
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("simulation timed out at cycle %0d with %0d results pending",
                     cycle, exp_q.size());
            $display("Testbench failed");
            $finish;
        end
    end

    // scoreboard, sampled mid-cycle.
    always @(negedge clk) begin : compare
        exp_t e;
        if (rst) begin
            if (wb_valid !== 1'b0) begin
                $display("wb_valid is not low during reset at %0t", $time);
                flow_errs++;
            end
        end else if (wb_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("wb_valid at %0t with no operation outstanding", $time);
                flow_errs++;
            end else begin
                e = exp_q.pop_front();
                if (cycle != e.due) begin
                    $display("result for tag %h arrived at cycle %0d, expected cycle %0d",
                             e.tag, cycle, e.due);
                    flow_errs++;
                end
                check_word("wb_data", e.data, wb_data);
                check_tag("wb_tag", e.tag, wb_tag);
                check_pc("wb_pc", e.pc, wb_pc);
            end
        end else begin
            if (wb_valid !== 1'b0) begin
                $display("wb_valid is unknown at %0t", $time);
                flow_errs++;
            end
            if (exp_q.size() != 0 && cycle >= exp_q[0].due) begin
                e = exp_q.pop_front();
                $display("result for tag %h never arrived by cycle %0d", e.tag, e.due);
                flow_errs++;
            end
        end
    end

    initial begin
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue_op    = OP_DIV;
        issue_a     = '0;
        issue_b     = '0;
        issue_tag   = '0;
        issue_pc    = '0;
        cycle       = 0;
        data_errs   = 0;
        tag_errs    = 0;
        pc_errs     = 0;
        flow_errs   = 0;
        issued      = 0;
        next_tag    = '0;
        next_pc     = 32'h0000_1000;
        void'($urandom(32'h3610b2fc));

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        idle_cycles(10);

        // unsigned directed cases.
        send_seq(OP_DIVU, 100, 7);
        send_seq(OP_REMU, 100, 7);
        send_seq(OP_DIVU, 5, 9);
        send_seq(OP_REMU, 5, 9);
        send_seq(OP_DIVU, 32'hdead_beef, 1);
        send_seq(OP_REMU, 32'hdead_beef, 1);
        send_seq(OP_DIVU, 32'hffff_ffff, 32'hffff_ffff);
        send_seq(OP_REMU, 32'hffff_ffff, 32'hffff_ffff);
        send_seq(OP_DIVU, 32'hffff_ffff, 3);
        send_seq(OP_REMU, 0, 5);
        idle_cycles(2);

        // signed, all four sign combinations.
        send_seq(OP_DIV, 20, 3);
        send_seq(OP_DIV, -20, 3);
        send_seq(OP_DIV, 20, -3);
        send_seq(OP_DIV, -20, -3);
        send_seq(OP_REM, 20, 3);
        send_seq(OP_REM, -20, 3);
        send_seq(OP_REM, 20, -3);
        send_seq(OP_REM, -20, -3);
        send_seq(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        send_seq(OP_REM, 32'h8000_0000, 32'hffff_ffff);
        send_seq(OP_DIV, 32'h8000_0000, 1);
        send_seq(OP_REM, 32'h7fff_ffff, 32'h8000_0000);
        idle_cycles(3);

        // divide by zero.
        send_seq(OP_DIV, 1234, 0);
        send_seq(OP_DIV, -1234, 0);
        send_seq(OP_DIVU, 1234, 0);
        send_seq(OP_DIVU, -1234, 0);
        send_seq(OP_REM, 1234, 0);
        send_seq(OP_REM, -1234, 0);
        send_seq(OP_REMU, 1234, 0);
        send_seq(OP_REMU, -1234, 0);
        idle_cycles(LATENCY + 5);

        // full rate.
        repeat (B2B_OPS) begin
            send_random();
        end
        idle_cycles(LATENCY + 5);

        // random gaps.
        repeat (GAP_OPS) begin
            send_random();
            idle_cycles($urandom_range(3));
        end
        idle_cycles(LATENCY + 10);

        if (exp_q.size() != 0) begin
            $display("%0d results still outstanding at the end of the run", exp_q.size());
            flow_errs++;
        end
        $display("%0d operations issued; errors: data %0d, tag %0d, pc %0d, flow %0d",
                 issued, data_errs, tag_errs, pc_errs, flow_errs);
        if (data_errs + tag_errs + pc_errs + flow_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== div_unit.f ====
+incdir+.
div_unit_pkg.sv
div_issue.sv
div_pipe.sv
div_result.sv
div_unit.sv
tb_div_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the divide unit testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f div_unit.f \
    --top-module tb_div_unit \
    -o tb_div_unit

# Keep the output even if the simulator exits with an error.
out=$(./obj_dir/tb_div_unit 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "Testbench passed"; then
    exit 0
else
    exit 1
fi
